//--- hw/imuPkg.sv
`default_nettype none

package imuPkg;

    // Sensor and bus timing
    localparam logic [6:0] DEV_ADDR = 7'h68;
    localparam int TICK_DIV = 161;
    localparam int TICK_W = $clog2(TICK_DIV);
    localparam logic [7:0] REG_PWR_MGMT = 8'h6B;
    localparam logic [7:0] REG_ACCEL_XH = 8'h3B;

    // Register map
    localparam logic [7:0] ADDR_CTRL = 8'h00;
    localparam logic [7:0] ADDR_THRESH = 8'h04;
    localparam logic [7:0] ADDR_STATUS = 8'h08;
    localparam logic [7:0] ADDR_X = 8'h0C;
    localparam logic [7:0] ADDR_Y = 8'h10;
    localparam logic [7:0] ADDR_Z = 8'h14;

    typedef struct packed {
        logic awvalid;
        logic [7:0] awaddr;
        logic wvalid;
        logic [31:0] wdata;
        logic [3:0] wstrb;
        logic bready;
        logic arvalid;
        logic [7:0] araddr;
        logic rready;
    } axiReqT;

    typedef struct packed {
        logic awready;
        logic wready;
        logic bvalid;
        logic [1:0] bresp;
        logic arready;
        logic rvalid;
        logic [31:0] rdata;
        logic [1:0] rresp;
    } axiRspT;

    // skipByte turns the command into a bare stop condition
    typedef struct packed {
        logic start;
        logic stop;
        logic read;
        logic lastRead;
        logic skipByte;
        logic [7:0] data;
    } i2cCmdT;

    typedef struct packed {
        logic [7:0] data;
        logic nack;
        logic done;
    } i2cRspT;

    typedef struct packed {
        logic sclLow;
        logic sdaLow;
    } i2cPadT;

    // Filled bytewise from the bus, read as one signed value
    typedef union packed {
        struct packed {
            logic [7:0] hi;
            logic [7:0] lo;
        } bytes;
        logic signed [15:0] value;
    } axisSampleU;

    typedef struct packed {
        axisSampleU x;
        axisSampleU y;
        axisSampleU z;
        logic valid;
    } imuSampleT;

    typedef struct packed {
        logic enable;
        logic [14:0] thresh;
    } imuCfgT;

    typedef struct packed {
        logic busy;
        logic nackSeen;
        logic [7:0] scanCount;
    } imuStatusT;

endpackage

`default_nettype wire

//--- hw/i2cMaster.sv
`timescale 1ns/1ps
`default_nettype none

module i2cMaster import imuPkg::*; (
    input  logic   MCLK,
    input  logic   nRST,
    input  i2cCmdT cmd,
    input  logic   cmdValid,
    output logic   cmdReady,
    output i2cRspT rsp,
    input  logic   sclIn,
    input  logic   sdaIn,
    output i2cPadT pad
);

    typedef enum logic [1:0] {S_IDLE, S_START, S_BITS, S_STOP} stateT;

    stateT state;
    logic [TICK_W-1:0] preCnt;
    logic tick;
    logic hold;
    logic [1:0] qtr;
    logic [3:0] bitCnt;
    logic [1:0] sclQ;
    logic [1:0] sdaQ;
    logic [8:0] txShift;
    logic [8:0] rxShift;
    i2cCmdT cur;

    // Quarter-bit tick
    always_ff @(posedge MCLK or negedge nRST) begin
        if (!nRST) begin
            preCnt <= '0;
        end else if (tick) begin
            preCnt <= '0;
        end else begin
            preCnt <= preCnt + 1'b1;
        end
    end

    assign tick = (preCnt == TICK_W'(TICK_DIV - 1));

    // Two-stage sync of the bus lines
    always_ff @(posedge MCLK or negedge nRST) begin
        if (!nRST) begin
            sclQ <= 2'b11;
            sdaQ <= 2'b11;
        end else begin
            sclQ <= {sclQ[0], sclIn};
            sdaQ <= {sdaQ[0], sdaIn};
        end
    end

    // Commands start on tick boundaries only
    assign cmdReady = (state == S_IDLE) && tick;
    // Sampling quarter waits for SCL to be seen high
    assign hold = (state == S_BITS) && (qtr == 2'd2) && !sclQ[1];

    // Reads shift out all ones, ack bit is lastRead (NACK on the final byte)
    always_ff @(posedge MCLK) begin
        if (cmdValid && cmdReady) begin
            cur <= cmd;
            txShift <= cmd.read ? {8'hFF, cmd.lastRead} : {cmd.data, 1'b1};
        end else if (tick && !hold && state == S_BITS) begin
            if (qtr == 2'd2) begin
                rxShift <= {rxShift[7:0], sdaQ[1]};
            end
            if (qtr == 2'd3) begin
                txShift <= {txShift[7:0], 1'b1};
            end
        end
    end

    always_ff @(posedge MCLK or negedge nRST) begin
        if (!nRST) begin
            state <= S_IDLE;
            qtr <= '0;
            bitCnt <= '0;
            pad <= '0;
            rsp <= '0;
        end else begin
            rsp.done <= 1'b0;
            if (cmdValid && cmdReady) begin
                qtr <= '0;
                bitCnt <= '0;
                rsp.nack <= 1'b0;
                if (cmd.start) begin
                    state <= S_START;
                end else if (cmd.skipByte) begin
                    state <= S_STOP;
                end else begin
                    state <= S_BITS;
                end
            end else if (tick && !hold && state != S_IDLE) begin
                qtr <= qtr + 1'b1;
                case (state)
                    S_START: begin
                        case (qtr)
                            2'd0: pad.sdaLow <= 1'b0;
                            2'd1: pad.sclLow <= 1'b0;
                            2'd2: pad.sdaLow <= 1'b1;
                            default: begin
                                pad.sclLow <= 1'b1;
                                state <= S_BITS;
                            end
                        endcase
                    end
                    S_BITS: begin
                        case (qtr)
                            2'd0: pad.sdaLow <= ~txShift[8];
                            2'd1: pad.sclLow <= 1'b0;
                            2'd3: begin
                                pad.sclLow <= 1'b1;
                                bitCnt <= bitCnt + 1'b1;
                                if (bitCnt == 4'd8) begin
                                    rsp.data <= rxShift[8:1];
                                    rsp.nack <= !cur.read && rxShift[0];
                                    if (cur.stop) begin
                                        state <= S_STOP;
                                    end else begin
                                        state <= S_IDLE;
                                        rsp.done <= 1'b1;
                                    end
                                end
                            end
                            default: ;
                        endcase
                    end
                    S_STOP: begin
                        case (qtr)
                            2'd0: pad.sdaLow <= 1'b1;
                            2'd1: pad.sclLow <= 1'b0;
                            2'd2: pad.sdaLow <= 1'b0;
                            default: begin
                                state <= S_IDLE;
                                rsp.done <= 1'b1;
                            end
                        endcase
                    end
                    default: ;
                endcase
            end
        end
    end

    // One line at a time, so no false start or stop mid-transfer
    assert property (@(posedge MCLK) disable iff (!nRST)
        (state != S_IDLE) |-> !($changed(pad.sclLow) && $changed(pad.sdaLow)))
        else $error("SCL and SDA drive changed in the same cycle");

endmodule

`default_nettype wire

//--- hw/imuSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module imuSequencer import imuPkg::*; (
    input  logic      MCLK,
    input  logic      nRST,
    input  imuCfgT    cfg,
    output i2cCmdT    cmd,
    output logic      cmdValid,
    input  logic      cmdReady,
    input  i2cRspT    rsp,
    output imuSampleT sample,
    output logic      busy,
    output logic      nackPulse
);

    typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_WAIT} stateT;

    stateT state;
    logic wakePh;
    logic abort;
    logic [3:0] step;
    logic lastStep;
    logic validQ;
    axisSampleU xQ;
    axisSampleU yQ;
    axisSampleU zQ;

    // Byte command for the current step
    always_comb begin
        cmd = '0;
        if (abort) begin
            cmd.skipByte = 1'b1;
            cmd.stop = 1'b1;
        end else if (wakePh) begin
            case (step)
                4'd0: begin
                    cmd.start = 1'b1;
                    cmd.data = {DEV_ADDR, 1'b0};
                end
                4'd1: cmd.data = REG_PWR_MGMT;
                // Writing zero clears the sleep bit
                default: cmd.stop = 1'b1;
            endcase
        end else begin
            case (step)
                4'd0: begin
                    cmd.start = 1'b1;
                    cmd.data = {DEV_ADDR, 1'b0};
                end
                4'd1: cmd.data = REG_ACCEL_XH;
                4'd2: begin
                    cmd.start = 1'b1;
                    cmd.data = {DEV_ADDR, 1'b1};
                end
                default: begin
                    cmd.read = 1'b1;
                    cmd.lastRead = (step == 4'd8);
                    cmd.stop = (step == 4'd8);
                end
            endcase
        end
    end

    assign lastStep = abort || (wakePh ? step == 4'd2 : step == 4'd8);
    assign cmdValid = (state == S_ISSUE);
    assign busy = (state != S_IDLE);
    assign sample = '{x: xQ, y: yQ, z: zQ, valid: validQ};

    always_ff @(posedge MCLK or negedge nRST) begin
        if (!nRST) begin
            state <= S_IDLE;
            wakePh <= 1'b0;
            abort <= 1'b0;
            step <= '0;
            validQ <= 1'b0;
            nackPulse <= 1'b0;
        end else begin
            validQ <= 1'b0;
            nackPulse <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (cfg.enable) begin
                        state <= S_ISSUE;
                        wakePh <= 1'b1;
                        abort <= 1'b0;
                        step <= '0;
                    end
                end
                S_ISSUE: begin
                    if (cmdReady) begin
                        state <= S_WAIT;
                    end
                end
                default: begin
                    if (rsp.done) begin
                        if (rsp.nack) begin
                            nackPulse <= 1'b1;
                            // Bus still held, close it before retrying
                            if (cmd.stop) begin
                                state <= S_IDLE;
                            end else begin
                                abort <= 1'b1;
                                state <= S_ISSUE;
                            end
                        end else if (!lastStep) begin
                            step <= step + 1'b1;
                            state <= S_ISSUE;
                        end else begin
                            validQ <= !wakePh && !abort;
                            if (abort || !cfg.enable) begin
                                state <= S_IDLE;
                            end else begin
                                wakePh <= 1'b0;
                                step <= '0;
                                state <= S_ISSUE;
                            end
                        end
                    end
                end
            endcase
        end
    end

    // Burst order is XH XL YH YL ZH ZL
    always_ff @(posedge MCLK) begin
        if (state == S_WAIT && rsp.done && cmd.read) begin
            case (step)
                4'd3: xQ.bytes.hi <= rsp.data;
                4'd4: xQ.bytes.lo <= rsp.data;
                4'd5: yQ.bytes.hi <= rsp.data;
                4'd6: yQ.bytes.lo <= rsp.data;
                4'd7: zQ.bytes.hi <= rsp.data;
                default: zQ.bytes.lo <= rsp.data;
            endcase
        end
    end

    assert property (@(posedge MCLK) disable iff (!nRST)
        cmdValid && !cmdReady |=> cmdValid && $stable(cmd))
        else $error("Command withdrawn before the master took it");

endmodule

`default_nettype wire

//--- hw/tiltCompare.sv
`timescale 1ns/1ps
`default_nettype none

module tiltCompare import imuPkg::*; (
    input  logic      MCLK,
    input  logic      nRST,
    input  imuCfgT    cfg,
    input  imuSampleT sample,
    output logic      ledX,
    output logic      ledY,
    output logic      ledZ,
    output logic      ledSign
);

    logic [15:0] magX;
    logic [15:0] magY;
    logic [15:0] magZ;
    logic [15:0] magMax;
    logic [2:0] pick;
    logic neg;

    // Unsigned magnitude, -32768 maps to 0x8000
    function automatic logic [15:0] mag(input axisSampleU s);
        return s.value[15] ? 16'(-s.value) : 16'(s.value);
    endfunction

    assign magX = mag(sample.x);
    assign magY = mag(sample.y);
    assign magZ = mag(sample.z);

    // Ties favour X, then Y
    always_comb begin
        if (magX >= magY && magX >= magZ) begin
            pick = 3'b100;
            magMax = magX;
            neg = sample.x.value[15];
        end else if (magY >= magZ) begin
            pick = 3'b010;
            magMax = magY;
            neg = sample.y.value[15];
        end else begin
            pick = 3'b001;
            magMax = magZ;
            neg = sample.z.value[15];
        end
    end

    always_ff @(posedge MCLK or negedge nRST) begin
        if (!nRST) begin
            {ledX, ledY, ledZ, ledSign} <= 4'b0;
        end else if (sample.valid) begin
            if (magMax > {1'b0, cfg.thresh}) begin
                {ledX, ledY, ledZ} <= pick;
                ledSign <= neg;
            end else begin
                {ledX, ledY, ledZ, ledSign} <= 4'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/imuRegs.sv
`timescale 1ns/1ps
`default_nettype none

module imuRegs import imuPkg::*; (
    input  logic      MCLK,
    input  logic      nRST,
    input  axiReqT    axiReq,
    output axiRspT    axiRsp,
    input  imuSampleT sample,
    input  logic      busy,
    input  logic      nackPulse,
    output imuCfgT    cfg
);

    logic nackSeen;
    logic [7:0] scanCount;
    imuStatusT status;
    axisSampleU xQ;
    axisSampleU yQ;
    axisSampleU zQ;
    logic wrFire;
    logic rdFire;
    logic wrOk;
    logic rdOk;
    logic clrNack;
    logic [31:0] rdData;

    // Ready pulses only while both channels are valid
    assign wrFire = axiRsp.awready;
    assign rdFire = axiRsp.arready;
    assign wrOk = axiReq.awaddr inside {ADDR_CTRL, ADDR_THRESH, ADDR_STATUS,
                                        ADDR_X, ADDR_Y, ADDR_Z};
    assign clrNack = wrFire && axiReq.awaddr == ADDR_CTRL && axiReq.wstrb[0]
                     && axiReq.wdata[1];
    assign status = '{busy: busy, nackSeen: nackSeen, scanCount: scanCount};

    always_comb begin
        rdData = '0;
        rdOk = 1'b1;
        case (axiReq.araddr)
            ADDR_CTRL: rdData = {31'b0, cfg.enable};
            ADDR_THRESH: rdData = {17'b0, cfg.thresh};
            ADDR_STATUS: rdData = {16'b0, status.scanCount, 6'b0, status.nackSeen, status.busy};
            ADDR_X: rdData = {{16{xQ.value[15]}}, xQ.value};
            ADDR_Y: rdData = {{16{yQ.value[15]}}, yQ.value};
            ADDR_Z: rdData = {{16{zQ.value[15]}}, zQ.value};
            default: rdOk = 1'b0;
        endcase
    end

    always_ff @(posedge MCLK or negedge nRST) begin
        if (!nRST) begin
            axiRsp <= '0;
            cfg <= '0;
        end else begin
            axiRsp.awready <= 1'b0;
            axiRsp.wready <= 1'b0;
            axiRsp.arready <= 1'b0;
            if (axiReq.awvalid && axiReq.wvalid && !axiRsp.bvalid && !wrFire) begin
                axiRsp.awready <= 1'b1;
                axiRsp.wready <= 1'b1;
            end
            if (wrFire) begin
                axiRsp.bvalid <= 1'b1;
                axiRsp.bresp <= wrOk ? 2'b00 : 2'b10;
                if (axiReq.awaddr == ADDR_CTRL && axiReq.wstrb[0]) begin
                    cfg.enable <= axiReq.wdata[0];
                end
                if (axiReq.awaddr == ADDR_THRESH && axiReq.wstrb[0]) begin
                    cfg.thresh[7:0] <= axiReq.wdata[7:0];
                end
                if (axiReq.awaddr == ADDR_THRESH && axiReq.wstrb[1]) begin
                    cfg.thresh[14:8] <= axiReq.wdata[14:8];
                end
            end else if (axiRsp.bvalid && axiReq.bready) begin
                axiRsp.bvalid <= 1'b0;
            end
            if (axiReq.arvalid && !axiRsp.rvalid && !rdFire) begin
                axiRsp.arready <= 1'b1;
            end
            if (rdFire) begin
                axiRsp.rvalid <= 1'b1;
                axiRsp.rdata <= rdData;
                axiRsp.rresp <= rdOk ? 2'b00 : 2'b10;
            end else if (axiRsp.rvalid && axiReq.rready) begin
                axiRsp.rvalid <= 1'b0;
            end
        end
    end

    // A NACK in the same cycle as a clear wins
    always_ff @(posedge MCLK or negedge nRST) begin
        if (!nRST) begin
            nackSeen <= 1'b0;
            scanCount <= '0;
        end else begin
            if (nackPulse) begin
                nackSeen <= 1'b1;
            end else if (clrNack) begin
                nackSeen <= 1'b0;
            end
            if (sample.valid) begin
                scanCount <= scanCount + 1'b1;
            end
        end
    end

    always_ff @(posedge MCLK) begin
        if (sample.valid) begin
            xQ <= sample.x;
            yQ <= sample.y;
            zQ <= sample.z;
        end
    end

    assert property (@(posedge MCLK) disable iff (!nRST)
        axiRsp.bvalid && !axiReq.bready |=> axiRsp.bvalid)
        else $error("Write response dropped before bready");
    assert property (@(posedge MCLK) disable iff (!nRST)
        axiRsp.rvalid && !axiReq.rready |=> axiRsp.rvalid && $stable(axiRsp.rdata))
        else $error("Read response changed before rready");
    assert property (@(posedge MCLK) disable iff (!nRST)
        $rose(axiRsp.awready) |-> !axiRsp.bvalid)
        else $error("Write accepted while a response was pending");

endmodule

`default_nettype wire

//--- hw/imuTop.sv
`timescale 1ns/1ps
`default_nettype none

module imuTop import imuPkg::*; (
    input  logic   MCLK,
    input  logic   nRST,
    input  axiReqT axiReq,
    output axiRspT axiRsp,
    input  logic   sclIn,
    input  logic   sdaIn,
    output i2cPadT pad,
    output logic   ledX,
    output logic   ledY,
    output logic   ledZ,
    output logic   ledSign
);

    imuCfgT cfg;
    imuSampleT sample;
    i2cCmdT cmd;
    i2cRspT rsp;
    logic cmdValid;
    logic cmdReady;
    logic busy;
    logic nackPulse;

    imuRegs uRegs (
        .MCLK(MCLK), .nRST(nRST), .axiReq(axiReq), .axiRsp(axiRsp),
        .sample(sample), .busy(busy), .nackPulse(nackPulse), .cfg(cfg)
    );

    imuSequencer uSeq (
        .MCLK(MCLK), .nRST(nRST), .cfg(cfg), .cmd(cmd), .cmdValid(cmdValid),
        .cmdReady(cmdReady), .rsp(rsp), .sample(sample), .busy(busy),
        .nackPulse(nackPulse)
    );

    i2cMaster uI2c (
        .MCLK(MCLK), .nRST(nRST), .cmd(cmd), .cmdValid(cmdValid),
        .cmdReady(cmdReady), .rsp(rsp), .sclIn(sclIn), .sdaIn(sdaIn), .pad(pad)
    );

    tiltCompare uTilt (
        .MCLK(MCLK), .nRST(nRST), .cfg(cfg), .sample(sample),
        .ledX(ledX), .ledY(ledY), .ledZ(ledZ), .ledSign(ledSign)
    );

endmodule

`default_nettype wire

//--- verif/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic MCLK,
    output logic nRST
);

    // 100 ns period
    initial begin
        MCLK = 1'b0;
        forever #50 MCLK = ~MCLK;
    end

    initial begin
        nRST = 1'b0;
        repeat (4) @(posedge MCLK);
        nRST <= 1'b1;
    end

endmodule

`default_nettype wire

//--- verif/mpuSlaveModel.sv
`timescale 1ns/1ps
`default_nettype none

module mpuSlaveModel (
    input  wire  scl,
    input  wire  sda,
    input  wire  forceNack,
    output logic sdaLow
);

    localparam logic [6:0] SLAVE_ADDR = 7'h68;

    logic [7:0] regs [0:255];
    logic [7:0] served [0:5];
    logic [7:0] ptr;
    logic [7:0] shiftIn;
    logic [7:0] txByte;
    logic [7:0] wrReg;
    logic [7:0] wrData;
    logic [7:0] burstStart;
    logic addrPhase;
    logic ptrPhase;
    logic selected;
    logic reading;
    logic masterAck;
    int bitPos;
    int wrCount;

    initial begin
        for (int i = 0; i < 256; i++) begin
            regs[i] = 8'(i) ^ 8'hA5;
        end
        for (int i = 0; i < 6; i++) begin
            served[i] = 8'h00;
        end
        sdaLow = 1'b0;
        ptr = 8'h00;
        bitPos = 0;
        wrCount = 0;
        addrPhase = 1'b0;
        ptrPhase = 1'b0;
        selected = 1'b0;
        reading = 1'b0;
        masterAck = 1'b0;
        wrReg = 8'h00;
        wrData = 8'h00;
        burstStart = 8'h00;
    end

    // Start or repeated start
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            bitPos = 0;
            addrPhase = 1'b1;
            selected = 1'b0;
            reading = 1'b0;
            sdaLow = 1'b0;
        end
    end

    // Stop
    always @(posedge sda) begin
        if (scl === 1'b1) begin
            addrPhase = 1'b0;
            selected = 1'b0;
            reading = 1'b0;
            sdaLow = 1'b0;
        end
    end

    always @(posedge scl) begin
        if (bitPos < 8) begin
            shiftIn = {shiftIn[6:0], sda};
        end else begin
            masterAck = !sda;
        end
        bitPos++;
    end

    // Outputs change only while SCL is low
    always @(negedge scl) begin
        if (bitPos == 8) begin
            if (addrPhase) begin
                addrPhase = 1'b0;
                selected = (shiftIn[7:1] == SLAVE_ADDR) && !forceNack;
                reading = selected && shiftIn[0];
                ptrPhase = selected && !shiftIn[0];
                sdaLow = selected;
                if (reading) begin
                    burstStart = ptr;
                end
            end else if (selected && !reading) begin
                if (ptrPhase) begin
                    ptr = shiftIn;
                    ptrPhase = 1'b0;
                end else begin
                    regs[ptr] = shiftIn;
                    wrReg = ptr;
                    wrData = shiftIn;
                    wrCount++;
                    ptr = ptr + 8'd1;
                end
                sdaLow = !forceNack;
            end else begin
                sdaLow = 1'b0;
            end
        end else if (bitPos == 9) begin
            bitPos = 0;
            sdaLow = 1'b0;
            // Own address ack also reads as an ack here
            if (reading && masterAck) begin
                txByte = regs[ptr];
                if (ptr - burstStart < 8'd6) begin
                    served[ptr - burstStart] = txByte;
                end
                ptr = ptr + 8'd1;
                sdaLow = !txByte[7];
            end else begin
                reading = 1'b0;
            end
        end else if (reading && bitPos > 0 && bitPos < 8) begin
            sdaLow = !txByte[7 - bitPos];
        end
    end

endmodule

`default_nettype wire

//--- verif/tbTop.sv
`timescale 1ns/1ps
`default_nettype none

module tbTop import imuPkg::*; ();

    localparam int NUM_SCANS = 4;
    localparam int SCAN_CYCLES = 70000;
    // Wake-up, NACK phase and resumed scan need about four more scan lengths
    localparam int TIMEOUT_CYCLES = (NUM_SCANS + 4) * SCAN_CYCLES;

    logic MCLK;
    logic nRST;
    axiReqT axiReq;
    axiRspT axiRsp;
    i2cPadT pad;
    wire scl;
    wire sda;
    logic slaveSdaLow;
    logic forceNack;
    logic ledX;
    logic ledY;
    logic ledZ;
    logic ledSign;
    logic [14:0] thresh;
    logic [3:0] ledsExpected;
    logic [31:0] lfsr = 32'hd3291138;
    int valueErrors = 0;
    int ledErrors = 0;
    int cycleCount = 0;

    tbClock clockGen (.MCLK(MCLK), .nRST(nRST));

    imuTop dut (
        .MCLK(MCLK), .nRST(nRST), .axiReq(axiReq), .axiRsp(axiRsp),
        .sclIn(scl), .sdaIn(sda), .pad(pad),
        .ledX(ledX), .ledY(ledY), .ledZ(ledZ), .ledSign(ledSign)
    );

    mpuSlaveModel model (.scl(scl), .sda(sda), .forceNack(forceNack), .sdaLow(slaveSdaLow));

    // Open-drain bus
    assign scl = !pad.sclLow;
    assign sda = !(pad.sdaLow || slaveSdaLow);

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int absValue(input logic signed [15:0] v);
        return (v < 0) ? -int'(v) : int'(v);
    endfunction

    // Largest magnitude wins, earlier axis on a tie
    function automatic logic [3:0] expectLeds(input logic signed [15:0] x,
                                              input logic signed [15:0] y,
                                              input logic signed [15:0] z,
                                              input logic [14:0] limit);
        int best;
        logic [3:0] result;
        best = absValue(x);
        result = {3'b100, x < 0};
        if (absValue(y) > best) begin
            best = absValue(y);
            result = {3'b010, y < 0};
        end
        if (absValue(z) > best) begin
            best = absValue(z);
            result = {3'b001, z < 0};
        end
        return (best > int'(limit)) ? result : 4'b0;
    endfunction

    assign ledsExpected = expectLeds({model.served[0], model.served[1]},
                                     {model.served[2], model.served[3]},
                                     {model.served[4], model.served[5]}, thresh);

    assert property (@(posedge MCLK) disable iff (!nRST)
        dut.sample.valid |=> ({ledX, ledY, ledZ, ledSign} == ledsExpected))
        else begin
            ledErrors++;
            $display("MISMATCH at %0t: indicators %b, expected %b", $time,
                     {ledX, ledY, ledZ, ledSign}, ledsExpected);
        end

    always @(posedge MCLK) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic expectEqual(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            valueErrors++;
            $display("MISMATCH at %0t: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic writeReg(input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output logic [1:0] resp);
        @(posedge MCLK);
        axiReq.awvalid <= 1'b1;
        axiReq.awaddr <= addr;
        axiReq.wvalid <= 1'b1;
        axiReq.wdata <= data;
        axiReq.wstrb <= strb;
        do @(posedge MCLK); while (!axiRsp.awready);
        expectEqual("wready with awready", {31'b0, axiRsp.wready}, 32'h1);
        axiReq.awvalid <= 1'b0;
        axiReq.wvalid <= 1'b0;
        do @(posedge MCLK); while (!axiRsp.bvalid);
        resp = axiRsp.bresp;
        // Response waits a cycle before it is accepted
        @(posedge MCLK);
        axiReq.bready <= 1'b1;
        @(posedge MCLK);
        axiReq.bready <= 1'b0;
    endtask

    task automatic readReg(input logic [7:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
        @(posedge MCLK);
        axiReq.arvalid <= 1'b1;
        axiReq.araddr <= addr;
        do @(posedge MCLK); while (!axiRsp.arready);
        axiReq.arvalid <= 1'b0;
        do @(posedge MCLK); while (!axiRsp.rvalid);
        data = axiRsp.rdata;
        resp = axiRsp.rresp;
        // Data must hold while rready stays low
        @(posedge MCLK);
        axiReq.rready <= 1'b1;
        @(posedge MCLK);
        axiReq.rready <= 1'b0;
    endtask

    task automatic drawByte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsrNext(lfsr);
            b = {b[6:0], lfsr[0]};
        end
    endtask

    // New accelerometer bytes, returns the dominant magnitude
    task automatic loadAxes(output int dom);
        logic [7:0] b [0:5];
        for (int i = 0; i < 6; i++) begin
            drawByte(b[i]);
            model.regs[8'h3B + i] <= b[i];
        end
        dom = absValue({b[0], b[1]});
        for (int i = 1; i < 3; i++) begin
            if (absValue({b[2 * i], b[2 * i + 1]}) > dom) begin
                dom = absValue({b[2 * i], b[2 * i + 1]});
            end
        end
    endtask

    task automatic setThreshold(input int value);
        logic [1:0] resp;
        writeReg(ADDR_THRESH, 32'(value), 4'b0011, resp);
        thresh = 15'(value);
    endtask

    task automatic waitScan(inout logic [7:0] count);
        logic [31:0] d;
        logic [1:0] r;
        do readReg(ADDR_STATUS, d, r); while (d[15:8] == count);
        expectEqual("scan count", d[15:8], count + 8'd1);
        count = d[15:8];
    endtask

    task automatic checkSamples();
        logic [31:0] d;
        logic [1:0] r;
        logic [15:0] w;
        for (int i = 0; i < 3; i++) begin
            w = {model.served[2 * i], model.served[2 * i + 1]};
            readReg(ADDR_X + 8'(4 * i), d, r);
            expectEqual("axis sample", d, {{16{w[15]}}, w});
        end
    endtask

    initial begin
        logic [31:0] d;
        logic [1:0] r;
        logic [31:0] saved [0:2];
        logic [7:0] count;
        int dom;
        int t;
        axiReq = '0;
        forceNack = 1'b0;
        thresh = '0;
        count = '0;
        @(posedge nRST);
        @(posedge MCLK);

        // Idle after reset
        expectEqual("pad enables", {30'b0, pad}, 32'h0);
        expectEqual("indicators", {28'b0, ledX, ledY, ledZ, ledSign}, 32'h0);
        readReg(ADDR_CTRL, d, r);
        expectEqual("CTRL", d, 32'h0);
        readReg(ADDR_STATUS, d, r);
        expectEqual("STATUS", d, 32'h0);

        // Strobed writes and error responses
        writeReg(ADDR_THRESH, 32'h1234_5678, 4'b0011, r);
        writeReg(ADDR_THRESH, 32'h0000_AB00, 4'b0010, r);
        readReg(ADDR_THRESH, d, r);
        expectEqual("THRESH", d, 32'h0000_2B78);
        writeReg(ADDR_CTRL, 32'h1, 4'b0000, r);
        readReg(ADDR_CTRL, d, r);
        expectEqual("CTRL without strobe", d, 32'h0);
        writeReg(ADDR_STATUS, 32'hFFFF_FFFF, 4'b1111, r);
        expectEqual("STATUS write response", {30'b0, r}, 32'h0);
        readReg(ADDR_STATUS, d, r);
        expectEqual("STATUS after write", d, 32'h0);
        writeReg(8'h18, 32'h1, 4'b1111, r);
        expectEqual("unmapped write response", {30'b0, r}, 32'h2);
        readReg(8'h18, d, r);
        expectEqual("unmapped read response", {30'b0, r}, 32'h2);
        expectEqual("unmapped read data", d, 32'h0);

        // Threshold alternates just below and equal to the dominant magnitude
        for (int s = 0; s < NUM_SCANS; s++) begin
            loadAxes(dom);
            t = (s % 2 == 0) ? dom - 1 : dom;
            setThreshold((t < 0) ? 0 : ((t > 32767) ? 32767 : t));
            if (s == 0) begin
                writeReg(ADDR_CTRL, 32'h1, 4'b0001, r);
                readReg(ADDR_CTRL, d, r);
                expectEqual("CTRL after enable", d, 32'h1);
            end
            waitScan(count);
            checkSamples();
            if (s == 0) begin
                expectEqual("wake register", {24'b0, model.wrReg}, 32'h6B);
                expectEqual("wake data", {24'b0, model.wrData}, 32'h00);
                expectEqual("burst start", {24'b0, model.burstStart}, 32'h3B);
                expectEqual("wake write count", 32'(model.wrCount), 32'h1);
            end
        end

        // Sensor stops acknowledging
        @(posedge MCLK);
        forceNack <= 1'b1;
        do readReg(ADDR_STATUS, d, r); while (!d[1]);
        count = d[15:8];
        for (int i = 0; i < 3; i++) begin
            readReg(ADDR_X + 8'(4 * i), saved[i], r);
        end
        repeat (20000) @(posedge MCLK);
        for (int i = 0; i < 3; i++) begin
            readReg(ADDR_X + 8'(4 * i), d, r);
            expectEqual("sample held over NACK", d, saved[i]);
        end
        readReg(ADDR_STATUS, d, r);
        expectEqual("scan count over NACK", d[15:8], count);

        @(posedge MCLK);
        forceNack <= 1'b0;
        repeat (10000) @(posedge MCLK);
        writeReg(ADDR_CTRL, 32'h3, 4'b0001, r);
        readReg(ADDR_STATUS, d, r);
        expectEqual("nackSeen after clear", {31'b0, d[1]}, 32'h0);
        loadAxes(dom);
        setThreshold((dom > 32767) ? 32767 : dom / 2);
        waitScan(count);
        checkSamples();

        $display("Errors: %0d value, %0d indicator", valueErrors, ledErrors);
        if (valueErrors + ledErrors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
hw/imuPkg.sv
hw/i2cMaster.sv
hw/imuSequencer.sv
hw/tiltCompare.sv
hw/imuRegs.sv
hw/imuTop.sv
verif/tbClock.sv
verif/mpuSlaveModel.sv
verif/tbTop.sv

//--- Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tbTop -f tb.f -o simv
	./obj_dir/simv | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
